//--- hw/wb2sdr_pkg.sv
// Wishbone to SDRAM controller bridge, shared definitions
// Widths, queue depths, queue word layouts and decode enums
`default_nettype none

package wb2sdr_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------
  // Wishbone data word
  localparam int DATA_W = 32;
  // One enable per byte lane
  localparam int BE_W = DATA_W / 8;
  // Application address into the controller
  localparam int APP_AW = 26;
  // Controller burst length field, zero means one transfer
  localparam int BL_W = 9;

  // ----------------------------------------------------------------------
  // Queue depths, powers of two
  // ----------------------------------------------------------------------
  localparam int CMD_DEPTH = 4;
  localparam int WDATA_DEPTH = 8;
  // One pending read at most, so this never fills
  localparam int RDATA_DEPTH = 4;

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [APP_AW-1:0] addr_t;

  // Command toward the controller, 36 bits
  typedef struct packed {
    addr_t addr;
    logic [BL_W-1:0] len;
    logic wr_n;            // Low for write, high for read
  } sdr_cmd_t;

  // Write beat with active-low byte enables, 36 bits
  typedef struct packed {
    logic [BE_W-1:0] be_n;
    data_t data;
  } sdr_wdata_t;

  // Decoded Wishbone operation
  typedef enum logic [1:0] {
    OP_IDLE = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ = 2'd2
  } bus_op_e;

  // Read tracker, one read outstanding
  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_PENDING = 1'b1
  } rd_state_e;

endpackage

`default_nettype wire

//--- hw/sync_fifo.sv
// Single-clock FIFO of power-of-two depth
// Circular buffer with registered full and empty flags
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  wire logic             sdram_clk,
  input  wire logic             wb_clk_i,
  input  wire logic             push_i,
  input  wire logic [WIDTH-1:0] push_data_i,
  input  wire logic             pop_i,
  output logic      [WIDTH-1:0] pop_data_o,
  output logic                  full_o,
  output logic                  empty_o
);

  // Payload storage
  logic [WIDTH-1:0] mem [DEPTH];

  // Pointers wrap naturally at DEPTH
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH)-1:0] wr_ptr_nxt;
  logic [$clog2(DEPTH)-1:0] rd_ptr_nxt;

  // Qualified strobes drop overflow and underflow
  logic do_push;
  logic do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop = pop_i & ~empty_o;
  assign wr_ptr_nxt = wr_ptr + 1'b1;
  assign rd_ptr_nxt = rd_ptr + 1'b1;

  // ----------------------------------------------------------------------
  // Pointers and flags
  // ----------------------------------------------------------------------
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full_o <= 1'b0;
      empty_o <= 1'b1;
    end else begin
      if (do_push) wr_ptr <= wr_ptr_nxt;
      if (do_pop) rd_ptr <= rd_ptr_nxt;
      // Occupancy changes only when one side moves alone
      if (do_push && !do_pop) begin
        empty_o <= 1'b0;
        full_o <= (wr_ptr_nxt == rd_ptr);
      end else if (do_pop && !do_push) begin
        full_o <= 1'b0;
        empty_o <= (rd_ptr_nxt == wr_ptr);
      end
    end
  end

  // Write port
  always_ff @(posedge sdram_clk) begin
    if (do_push) mem[wr_ptr] <= push_data_i;
  end

  // Show-ahead head of queue
  assign pop_data_o = mem[rd_ptr];

endmodule

`default_nettype wire

//--- hw/wb_req_decode.sv
// Wishbone request decode
// Builds acknowledge and queue strobes, tracks the single pending read
`default_nettype none

module wb_req_decode import wb2sdr_pkg::*; (
  input  wire logic            sdram_clk,
  input  wire logic            wb_clk_i,
  // Wishbone slave side
  input  wire logic            wb_stb_i,
  input  wire logic            wb_cyc_i,
  input  wire logic            wb_we_i,
  input  wire addr_t           wb_addr_i,
  input  wire data_t           wb_dat_i,
  input  wire logic [BE_W-1:0] wb_sel_i,
  output logic                 wb_ack_o,
  // Queue status
  input  wire logic            cmd_full_i,
  input  wire logic            wdata_full_i,
  input  wire logic            rd_avail_i,
  // Queue strobes and words
  output logic                 cmd_push_o,
  output sdr_cmd_t             cmd_o,
  output logic                 wdata_push_o,
  output sdr_wdata_t           wdata_o,
  output logic                 rd_pop_o
);

  bus_op_e bus_op;
  rd_state_e rd_state;
  logic wr_room;

  // ----------------------------------------------------------------------
  // Cycle classification
  // ----------------------------------------------------------------------
  always_comb begin
    bus_op = OP_IDLE;
    if (wb_stb_i && wb_cyc_i) begin
      bus_op = wb_we_i ? OP_WRITE : OP_READ;
    end
  end

  // Write needs a slot in both queues
  assign wr_room = ~cmd_full_i & ~wdata_full_i;

  // Ack and strobes, purely combinational
  always_comb begin
    wb_ack_o = 1'b0;
    cmd_push_o = 1'b0;
    wdata_push_o = 1'b0;
    rd_pop_o = 1'b0;
    case (bus_op)
      OP_WRITE: begin
        // Zero-latency ack, command and data pushed together
        wb_ack_o = wr_room;
        cmd_push_o = wr_room;
        wdata_push_o = wr_room;
      end
      OP_READ: begin
        // Issue once, then wait for returned data
        cmd_push_o = (rd_state == RD_IDLE) & ~cmd_full_i;
        wb_ack_o = rd_avail_i;
        rd_pop_o = rd_avail_i;
      end
      default: ;
    endcase
  end

  // ----------------------------------------------------------------------
  // Pending read tracker
  // ----------------------------------------------------------------------
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (cmd_push_o && bus_op == OP_READ) rd_state <= RD_PENDING;
        RD_PENDING: if (rd_pop_o) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // Single transfer, length field zero
  assign cmd_o.addr = wb_addr_i;
  assign cmd_o.len = '0;
  assign cmd_o.wr_n = ~wb_we_i;

  // Controller wants active-low enables
  assign wdata_o.be_n = ~wb_sel_i;
  assign wdata_o.data = wb_dat_i;

endmodule

`default_nettype wire

//--- hw/sdr_cmd_issue.sv
// Controller-side issue
// Command and write-data queues feeding the SDRAM controller handshake
`default_nettype none

module sdr_cmd_issue import wb2sdr_pkg::*; (
  input  wire logic       sdram_clk,
  input  wire logic       wb_clk_i,
  // From the decoder
  input  wire logic       cmd_push_i,
  input  wire sdr_cmd_t   cmd_i,
  input  wire logic       wdata_push_i,
  input  wire sdr_wdata_t wdata_i,
  output logic            cmd_full_o,
  output logic            wdata_full_o,
  // Controller request handshake
  output logic            sdr_req_o,
  output sdr_cmd_t        sdr_req_cmd_o,
  input  wire logic       sdr_req_ack_i,
  // Controller write data
  input  wire logic       sdr_wr_next_i,
  output sdr_wdata_t      sdr_wr_o
);

  logic cmd_empty;

  // ----------------------------------------------------------------------
  // Command queue
  // ----------------------------------------------------------------------
  // Head stays stable until the controller acks it
  sync_fifo #(
    .WIDTH($bits(sdr_cmd_t)),
    .DEPTH(CMD_DEPTH)
  ) cmd_fifo_i (
    .sdram_clk  (sdram_clk),
    .wb_clk_i   (wb_clk_i),
    .push_i     (cmd_push_i),
    .push_data_i(cmd_i),
    .pop_i      (sdr_req_ack_i),
    .pop_data_o (sdr_req_cmd_o),
    .full_o     (cmd_full_o),
    .empty_o    (cmd_empty)
  );

  // Request held while anything waits
  assign sdr_req_o = ~cmd_empty;

  // ----------------------------------------------------------------------
  // Write-data queue
  // ----------------------------------------------------------------------
  // One beat per next-write strobe, empty tracked by the controller
  sync_fifo #(
    .WIDTH($bits(sdr_wdata_t)),
    .DEPTH(WDATA_DEPTH)
  ) wdata_fifo_i (
    .sdram_clk  (sdram_clk),
    .wb_clk_i   (wb_clk_i),
    .push_i     (wdata_push_i),
    .push_data_i(wdata_i),
    .pop_i      (sdr_wr_next_i),
    .pop_data_o (sdr_wr_o),
    .full_o     (wdata_full_o),
    .empty_o    ()
  );

endmodule

`default_nettype wire

//--- hw/sdr_rd_return.sv
// Read return path
// Queues read beats from the controller for the Wishbone read ack
`default_nettype none

module sdr_rd_return import wb2sdr_pkg::*; (
  input  wire logic  sdram_clk,
  input  wire logic  wb_clk_i,
  // Controller read beats
  input  wire logic  sdr_rd_valid_i,
  input  wire data_t sdr_rd_data_i,
  // Decoder side
  input  wire logic  rd_pop_i,
  output logic       rd_avail_o,
  output data_t      wb_dat_o
);

  logic rd_empty;

  // ----------------------------------------------------------------------
  // Read-data queue
  // ----------------------------------------------------------------------
  // Every valid beat is captured
  // Full flag left open, one pending read bounds occupancy
  sync_fifo #(
    .WIDTH(DATA_W),
    .DEPTH(RDATA_DEPTH)
  ) rdata_fifo_i (
    .sdram_clk  (sdram_clk),
    .wb_clk_i   (wb_clk_i),
    .push_i     (sdr_rd_valid_i),
    .push_data_i(sdr_rd_data_i),
    .pop_i      (rd_pop_i),
    .pop_data_o (wb_dat_o),
    .full_o     (),
    .empty_o    (rd_empty)
  );

  // Oldest word is on wb_dat_o whenever this is high
  assign rd_avail_o = ~rd_empty;

endmodule

`default_nettype wire

//--- hw/wb2sdr_top.sv
// Wishbone to SDRAM controller bridge, top level
// Request decode, controller-side issue and read return
`default_nettype none

module wb2sdr_top import wb2sdr_pkg::*; (
  input  wire logic            sdram_clk,
  input  wire logic            wb_clk_i,
  // Wishbone slave
  input  wire logic            wb_stb_i,
  input  wire logic            wb_cyc_i,
  input  wire logic            wb_we_i,
  input  wire addr_t           wb_addr_i,
  input  wire data_t           wb_dat_i,
  input  wire logic [BE_W-1:0] wb_sel_i,
  output logic                 wb_ack_o,
  output data_t                wb_dat_o,
  // SDRAM controller
  output logic                 sdr_req_o,
  output sdr_cmd_t             sdr_req_cmd_o,
  input  wire logic            sdr_req_ack_i,
  input  wire logic            sdr_wr_next_i,
  output sdr_wdata_t           sdr_wr_o,
  input  wire logic            sdr_rd_valid_i,
  input  wire data_t           sdr_rd_data_i
);

  // Decoder to issue
  logic cmd_push;
  sdr_cmd_t cmd;
  logic wdata_push;
  sdr_wdata_t wdata;
  logic cmd_full;
  logic wdata_full;
  // Return to decoder
  logic rd_avail;
  logic rd_pop;

  wb_req_decode wb_req_decode_i (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .wb_stb_i    (wb_stb_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_we_i     (wb_we_i),
    .wb_addr_i   (wb_addr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_ack_o    (wb_ack_o),
    .cmd_full_i  (cmd_full),
    .wdata_full_i(wdata_full),
    .rd_avail_i  (rd_avail),
    .cmd_push_o  (cmd_push),
    .cmd_o       (cmd),
    .wdata_push_o(wdata_push),
    .wdata_o     (wdata),
    .rd_pop_o    (rd_pop)
  );

  sdr_cmd_issue sdr_cmd_issue_i (
    .sdram_clk    (sdram_clk),
    .wb_clk_i     (wb_clk_i),
    .cmd_push_i   (cmd_push),
    .cmd_i        (cmd),
    .wdata_push_i (wdata_push),
    .wdata_i      (wdata),
    .cmd_full_o   (cmd_full),
    .wdata_full_o (wdata_full),
    .sdr_req_o    (sdr_req_o),
    .sdr_req_cmd_o(sdr_req_cmd_o),
    .sdr_req_ack_i(sdr_req_ack_i),
    .sdr_wr_next_i(sdr_wr_next_i),
    .sdr_wr_o     (sdr_wr_o)
  );

  sdr_rd_return sdr_rd_return_i (
    .sdram_clk     (sdram_clk),
    .wb_clk_i      (wb_clk_i),
    .sdr_rd_valid_i(sdr_rd_valid_i),
    .sdr_rd_data_i (sdr_rd_data_i),
    .rd_pop_i      (rd_pop),
    .rd_avail_o    (rd_avail),
    .wb_dat_o      (wb_dat_o)
  );

endmodule

`default_nettype wire

//--- verification/sdr_ctrl_model.sv
// Behavioral SDRAM controller for the bridge testbench
// Takes requests after LFSR-chosen delays, backed by a 16-word memory
`default_nettype none

module sdr_ctrl_model import wb2sdr_pkg::*; (
  input  wire logic       sdram_clk,
  input  wire logic       wb_clk_i,
  input  wire logic       sdr_req_i,
  input  wire sdr_cmd_t   sdr_req_cmd_i,
  output logic            sdr_req_ack_o,
  output logic            sdr_wr_next_o,
  input  wire sdr_wdata_t sdr_wr_i,
  output logic            sdr_rd_valid_o,
  output data_t           sdr_rd_data_o,
  // Copy of each accepted command for the testbench
  output logic            cmd_taken_o,
  output sdr_cmd_t        cmd_taken_val_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 16;
  localparam logic [31:0] LFSR_SEED = 32'h405a_7f7a;

  data_t mem [MEM_WORDS];
  logic [31:0] lfsr;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // ----------------------------------------------------------------------
  // One request, from accept delay to data beat
  // ----------------------------------------------------------------------
  task automatic serve_request();
    logic [2:0] delay;
    sdr_cmd_t cmd;
    sdr_wdata_t beat;
    logic [3:0] idx;
    delay = '0;
    // Three LFSR steps, one per delay bit
    for (int i = 0; i < 3; i++) begin
      lfsr = lfsr_step(lfsr);
      delay = {delay[1:0], lfsr[0]};
    end
    repeat (delay) @(negedge sdram_clk);
    cmd = sdr_req_cmd_i;
    idx = cmd.addr[3:0];
    sdr_req_ack_o = 1'b1;
    cmd_taken_o = 1'b1;
    cmd_taken_val_o = cmd;
    @(negedge sdram_clk);
    sdr_req_ack_o = 1'b0;
    cmd_taken_o = 1'b0;
    if (!cmd.wr_n) begin
      // Write beat, merged under active-low enables
      beat = sdr_wr_i;
      sdr_wr_next_o = 1'b1;
      @(negedge sdram_clk);
      sdr_wr_next_o = 1'b0;
      for (int b = 0; b < BE_W; b++) begin
        if (!beat.be_n[b]) mem[idx][8*b +: 8] = beat.data[8*b +: 8];
      end
    end else begin
      sdr_rd_valid_o = 1'b1;
      sdr_rd_data_o = mem[idx];
      @(negedge sdram_clk);
      sdr_rd_valid_o = 1'b0;
    end
  endtask

  initial begin
    sdr_req_ack_o = 1'b0;
    sdr_wr_next_o = 1'b0;
    sdr_rd_valid_o = 1'b0;
    sdr_rd_data_o = '0;
    cmd_taken_o = 1'b0;
    cmd_taken_val_o = '0;
    lfsr = LFSR_SEED;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = '0;
    // Requests looked at on the falling edge only
    forever begin
      @(negedge sdram_clk);
      if (!wb_clk_i && sdr_req_i) serve_request();
    end
  end

endmodule

`default_nettype wire

//--- verification/wb2sdr_tb.sv
// Testbench for the Wishbone to SDRAM controller bridge
// Replays bus operations from a stimulus file against a controller model
`default_nettype none

module wb2sdr_tb import wb2sdr_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 100;
  localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
  localparam int OP_CYCLES = 20;
  // Reset, idle check and drain at the end
  localparam int SETUP_CYCLES = 20;
  localparam string STIM_FILE = "verification/wb2sdr_stimulus.txt";

  logic sdram_clk;
  logic wb_clk_i;
  logic wb_stb_i;
  logic wb_cyc_i;
  logic wb_we_i;
  addr_t wb_addr_i;
  data_t wb_dat_i;
  logic [BE_W-1:0] wb_sel_i;
  logic wb_ack_o;
  data_t wb_dat_o;
  logic sdr_req_o;
  sdr_cmd_t sdr_req_cmd_o;
  logic sdr_req_ack_i;
  logic sdr_wr_next_i;
  sdr_wdata_t sdr_wr_o;
  logic sdr_rd_valid_i;
  data_t sdr_rd_data_i;
  logic cmd_taken;
  sdr_cmd_t cmd_taken_val;

  // Stimulus table with one entry per bus operation
  bus_op_e op_kind[$];
  addr_t op_addr[$];
  data_t op_data[$];
  logic [BE_W-1:0] op_sel[$];
  data_t op_expect[$];
  int n_ops = 0;
  // Commands the controller should see in bus order
  sdr_cmd_t exp_cmds[$];
  int cmds_seen = 0;
  // Write beats the controller should consume in bus order
  sdr_wdata_t exp_beats[$];
  int beats_seen = 0;

  always #(CLK_PERIOD / 2) sdram_clk = ~sdram_clk;

  wb2sdr_top wb2sdr_top_i (.*);

  sdr_ctrl_model sdr_ctrl_model_i (
    .sdram_clk      (sdram_clk),
    .wb_clk_i       (wb_clk_i),
    .sdr_req_i      (sdr_req_o),
    .sdr_req_cmd_i  (sdr_req_cmd_o),
    .sdr_req_ack_o  (sdr_req_ack_i),
    .sdr_wr_next_o  (sdr_wr_next_i),
    .sdr_wr_i       (sdr_wr_o),
    .sdr_rd_valid_o (sdr_rd_valid_i),
    .sdr_rd_data_o  (sdr_rd_data_i),
    .cmd_taken_o    (cmd_taken),
    .cmd_taken_val_o(cmd_taken_val)
  );

  // ----------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ----------------------------------------------------------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      stop_with_failure($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_rd_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      stop_with_failure($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_cmd(input string name, input sdr_cmd_t exp, input sdr_cmd_t act);
    if (exp !== act) begin
      stop_with_failure($sformatf(
        "[FAIL] %s expected addr %h len %0d wr_n %b actual addr %h len %0d wr_n %b",
        name, exp.addr, exp.len, exp.wr_n, act.addr, act.len, act.wr_n));
    end
  endtask

  task automatic check_wr_beat(input string name, input sdr_wdata_t exp,
                               input sdr_wdata_t act);
    if (exp !== act) begin
      stop_with_failure($sformatf(
        "[FAIL] %s expected be_n %b data %h actual be_n %b data %h",
        name, exp.be_n, exp.data, act.be_n, act.data));
    end
  endtask

  // Each command taken by the model against the bus order
  task automatic check_taken_cmd();
    sdr_cmd_t cmd_exp;
    if (exp_cmds.size() == 0) begin
      stop_with_failure("Controller took a command that no bus cycle issued");
    end else begin
      cmd_exp = exp_cmds.pop_front();
      check_cmd($sformatf("command %0d", cmds_seen), cmd_exp, cmd_taken_val);
      cmds_seen++;
    end
  endtask

  // Each write beat the model consumes against the bus order
  task automatic check_taken_beat();
    sdr_wdata_t beat_exp;
    if (exp_beats.size() == 0) begin
      stop_with_failure("Controller consumed a write beat that no bus write issued");
    end else begin
      beat_exp = exp_beats.pop_front();
      check_wr_beat($sformatf("write beat %0d", beats_seen), beat_exp, sdr_wr_o);
      beats_seen++;
    end
  endtask

  always @(posedge sdram_clk) begin
    if (cmd_taken) check_taken_cmd();
  end

  // Beat sampled mid-cycle while next-write is high
  always begin
    @(negedge sdram_clk);
    #(SAMPLE_DELAY);
    if (sdr_wr_next_i) check_taken_beat();
  end

  // ----------------------------------------------------------------------
  // Stimulus file reader
  // ----------------------------------------------------------------------
  task automatic load_stimulus();
    int fd;
    int n_fields;
    int line_no;
    string line;
    logic [7:0] op_ch;
    addr_t addr;
    data_t data;
    logic [BE_W-1:0] sel;
    data_t expect_rd;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) stop_with_failure("Could not open the stimulus file");
    line_no = 0;
    while ($fgets(line, fd) != 0) begin
      line_no++;
      // Skip comments and blank lines
      if (line.len() < 2 || line[0] == "#") continue;
      n_fields = $sscanf(line, "%c %h %h %h %h", op_ch, addr, data, sel, expect_rd);
      if (n_fields != 5) begin
        stop_with_failure($sformatf("Stimulus line %0d is malformed", line_no));
      end
      case (op_ch)
        "W": op_kind.push_back(OP_WRITE);
        "R": op_kind.push_back(OP_READ);
        default: stop_with_failure($sformatf("Unknown operation on line %0d", line_no));
      endcase
      op_addr.push_back(addr);
      op_data.push_back(data);
      op_sel.push_back(sel);
      op_expect.push_back(expect_rd);
    end
    $fclose(fd);
    if (op_kind.size() == 0) stop_with_failure("The stimulus file holds no operations");
    n_ops = op_kind.size();
  endtask

  // ----------------------------------------------------------------------
  // Wishbone master for one single-beat cycle
  // ----------------------------------------------------------------------
  task automatic run_bus_op(input int idx);
    sdr_cmd_t cmd_exp;
    sdr_wdata_t beat_exp;
    @(negedge sdram_clk);
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    wb_we_i = (op_kind[idx] == OP_WRITE);
    wb_addr_i = op_addr[idx];
    wb_dat_i = op_data[idx];
    wb_sel_i = op_sel[idx];
    // Single transfer with write-not low for writes
    cmd_exp.addr = op_addr[idx];
    cmd_exp.len = '0;
    cmd_exp.wr_n = (op_kind[idx] == OP_READ);
    exp_cmds.push_back(cmd_exp);
    // Write beat carries the inverted select as active-low enables
    if (op_kind[idx] == OP_WRITE) begin
      beat_exp.be_n = ~op_sel[idx];
      beat_exp.data = op_data[idx];
      exp_beats.push_back(beat_exp);
    end
    // Ack sampled mid-cycle and the transfer ends on the next rising edge
    #(SAMPLE_DELAY);
    while (!wb_ack_o) begin
      @(negedge sdram_clk);
      #(SAMPLE_DELAY);
    end
    if (op_kind[idx] == OP_READ) begin
      check_rd_data($sformatf("read %0d at %h", idx, op_addr[idx]), op_expect[idx], wb_dat_o);
    end
  endtask

  // Budget grows with the number of operations
  initial begin
    wait (n_ops != 0);
    #((n_ops * OP_CYCLES + SETUP_CYCLES) * CLK_PERIOD);
    stop_with_failure("Timeout, the bus hung before all operations finished");
  end

  initial begin
    sdram_clk = 1'b0;
    wb_clk_i = 1'b1;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i = 1'b0;
    wb_addr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    load_stimulus();
    repeat (3) @(posedge sdram_clk);
    @(negedge sdram_clk);
    wb_clk_i = 1'b0;
    // Quiet bus after reset
    repeat (4) begin
      @(negedge sdram_clk);
      #(SAMPLE_DELAY);
      check_flag("idle ack", 1'b0, wb_ack_o);
      check_flag("idle request", 1'b0, sdr_req_o);
    end
    for (int i = 0; i < n_ops; i++) run_bus_op(i);
    @(negedge sdram_clk);
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_we_i = 1'b0;
    // Trailing writes drain to the model
    while (exp_cmds.size() != 0) @(negedge sdram_clk);
    repeat (10) @(negedge sdram_clk);
    if (exp_beats.size() != 0) begin
      stop_with_failure("Some bus writes never delivered their data to the controller");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- build.f
hw/wb2sdr_pkg.sv
hw/sync_fifo.sv
hw/wb_req_decode.sv
hw/sdr_cmd_issue.sv
hw/sdr_rd_return.sv
hw/wb2sdr_top.sv
verification/sdr_ctrl_model.sv
verification/wb2sdr_tb.sv

//--- Makefile
# Verilator build and run for the Wishbone to SDRAM bridge testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= wb2sdr_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/wb2sdr_stimulus.txt
# op addr data sel expect, all hex except op; expect is the read data, unused on writes
# W writes data under sel, R reads and compares with expect
W 0000001 11223344 f 00000000
R 0000001 00000000 f 11223344
W 0000002 a5a5a5a5 f 00000000
W 0000003 0badf00d f 00000000
R 0000002 00000000 f a5a5a5a5
R 0000003 00000000 f 0badf00d
W 0000002 ffffffff 1 00000000
W 0000002 00c30000 4 00000000
R 0000002 00000000 f a5c3a5ff
W 0100004 c0de0004 f 00000000
W 0100005 c0de0005 f 00000000
W 0100006 c0de0006 f 00000000
W 0100007 c0de0007 f 00000000
W 0100008 c0de0008 f 00000000
W 0100009 c0de0009 f 00000000
W 010000a c0de000a f 00000000
W 010000b c0de000b f 00000000
W 010000c c0de000c f 00000000
W 010000d c0de000d f 00000000
R 0100004 00000000 f c0de0004
R 0100009 00000000 f c0de0009
R 010000d 00000000 f c0de000d
